//--- autotest.f
+incdir+design
design/autotest_pkg.sv
design/byte_field_reg.sv
design/vector_loader.sv
design/uut_runner.sv
design/sd_sequencer.sv
design/result_serializer.sv
design/autotest_top.sv
verif/sd_card_model.sv
verif/tb_autotest.sv

//--- verif/tb_autotest.sv
// directed tests against the SD host model; card holds 4 blocks, the run limit assumes 2-cycle busy
`timescale 1ns/1ps
`include "autotest_cfg.svh"

module tb_autotest import autotest_pkg::*;
();

    localparam int BUSY_LEN    = 2;
    localparam int NBLK        = 4;
    // one byte handshake with the host, busy included
    localparam int BYTE_CYCLES = BUSY_LEN + 3;
    localparam int LIMIT = 4 * (`AT_TIMEOUT + 2 * `AT_WRITE_BYTES * BYTE_CYCLES) + 1000;

    logic        clk;
    logic        rst;
    logic        spi_busy;
    byte_t       spi_data_out;
    logic        spi_rst;
    logic        spi_r_block;
    logic        spi_r_byte;
    logic        spi_w_block;
    logic        spi_w_byte;
    block_addr_t spi_block_addr;
    byte_t       spi_data_in;
    logic        rst_uut;
    iv_t         iv_uut;
    key_t        key_uut;
    uut_out_t    block_o_uut;
    logic        end_uut;
    logic        halted;

    int    cycles = 0;
    int    stub_cnt = 0;
    int    end_after;
    logic  end_en;
    int    seed;
    int    test_errors;
    int    errors;
    int    tests_run;
    int    tests_failed;
    sig_t  exp_sig  [0:NBLK-1];
    byte_t exp_iter [0:NBLK-1];
    iv_t   exp_iv   [0:NBLK-1];
    key_t  exp_key  [0:NBLK-1];

    autotest_top DUT (
        .clk              (clk),
        .rst              (rst),
        .spi_busy_i       (spi_busy),
        .spi_data_out_i   (spi_data_out),
        .spi_rst_o        (spi_rst),
        .spi_r_block_o    (spi_r_block),
        .spi_r_byte_o     (spi_r_byte),
        .spi_w_block_o    (spi_w_block),
        .spi_w_byte_o     (spi_w_byte),
        .spi_block_addr_o (spi_block_addr),
        .spi_data_in_o    (spi_data_in),
        .rst_uut_o        (rst_uut),
        .iv_uut_o         (iv_uut),
        .key_uut_o        (key_uut),
        .block_o_uut_i    (block_o_uut),
        .end_uut_i        (end_uut),
        .halted_o         (halted)
    );

    sd_card_model #(.BUSY_LEN(BUSY_LEN), .NBLK(NBLK)) card (
        .clk              (clk),
        .rst              (rst),
        .spi_rst_i        (spi_rst),
        .spi_r_block_i    (spi_r_block),
        .spi_r_byte_i     (spi_r_byte),
        .spi_w_block_i    (spi_w_block),
        .spi_w_byte_i     (spi_w_byte),
        .spi_block_addr_i (spi_block_addr),
        .spi_data_in_i    (spi_data_in),
        .spi_busy_o       (spi_busy),
        .spi_data_out_o   (spi_data_out)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // UUT stand-in, ends K cycles after its reset is released
    always @(negedge clk)
    begin
        block_o_uut <= iv_uut[63:0] ^ key_uut[63:0];
        if (rst_uut)
        begin
            stub_cnt = 0;
            end_uut <= 1'b0;
        end
        else if (end_en && stub_cnt == end_after)
            end_uut <= 1'b1;
        else
            stub_cnt = stub_cnt + 1;
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= LIMIT)
        begin
            $display("run stopped after %0d cycles because a test never finished", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic check_byte(input byte_t got, input byte_t exp, input string what);
        if (got !== exp)
        begin
            $display("error at %0t ns: %s is %02h, expected %02h", $time, what, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_out(input uut_out_t got, input uut_out_t exp, input string what);
        if (got !== exp)
        begin
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_timer(input timer_t got, input timer_t exp, input string what);
        if (got !== exp)
        begin
            $display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_addr(input block_addr_t got, input block_addr_t exp, input string what);
        if (got !== exp)
        begin
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            test_errors++;
        end
    endtask

    task automatic report_fault(input string what);
        $display("at %0t ns: %s", $time, what);
        test_errors++;
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst = 1'b1;
        repeat (10) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic fill_card();
        int a;
        for (a = 0; a < NBLK * `AT_BLOCK_BYTES; a++)
            card.store[a] = byte_t'(a ^ (a >> 8) ^ 8'h5A);
    endtask

    // header of one card block with random IV and key
    task automatic prepare_block(input int blk, input bit good);
        int    base;
        int    i;
        sig_t  sig;
        iv_t   iv;
        key_t  key;
        byte_t iter;
        base = blk * `AT_BLOCK_BYTES;
        sig  = good ? sig_t'(`AT_SIG_VALUE) : 32'h1234_5678;
        iter = byte_t'($random(seed));
        for (i = 0; i < 4; i++)
            card.store[base + `AT_OFS_SIG + i] = sig[8*(3-i) +: 8];
        card.store[base + `AT_OFS_ITER] = iter;
        for (i = 0; i < `AT_IV_BYTES; i++)
        begin
            iv[8*i +: 8] = byte_t'($random(seed));
            card.store[base + `AT_OFS_IV + i] = iv[8*i +: 8];
        end
        for (i = 0; i < `AT_KEY_BYTES; i++)
        begin
            key[8*i +: 8] = byte_t'($random(seed));
            card.store[base + `AT_OFS_KEY + i] = key[8*i +: 8];
        end
        exp_sig[blk]  = sig;
        exp_iter[blk] = iter;
        exp_iv[blk]   = iv;
        exp_key[blk]  = key;
    endtask

    function automatic byte_t expected_byte(input int blk, input int i, input timer_t t);
        sig_t     sig;
        iv_t      iv;
        key_t     key;
        uut_out_t out;
        sig = exp_sig[blk];
        iv  = exp_iv[blk];
        key = exp_key[blk];
        out = iv[63:0] ^ key[63:0];
        if (i < `AT_OFS_ITER)
            return sig[8*(3-i) +: 8];
        if (i == `AT_OFS_ITER)
            return exp_iter[blk];
        if (i >= `AT_OFS_IV && i < `AT_OFS_IV + `AT_IV_BYTES)
            return iv[8*(i-`AT_OFS_IV) +: 8];
        if (i >= `AT_OFS_KEY && i < `AT_OFS_KEY + `AT_KEY_BYTES)
            return key[8*(i-`AT_OFS_KEY) +: 8];
        if (i >= `AT_OFS_OUT && i < `AT_OFS_OUT + `AT_OUT_BYTES)
            return out[8*(i-`AT_OFS_OUT) +: 8];
        if (i >= `AT_OFS_TIMER && i < `AT_OFS_TIMER + `AT_TIMER_BYTES)
            return t[8*(i-`AT_OFS_TIMER) +: 8];
        return 8'hFF;
    endfunction

    task automatic wait_writes(input int n);
        while (card.wr_count < n)
            @(posedge clk);
    endtask

    task automatic verify_record(input int rec, input int blk, input timer_t t);
        int       base;
        int       i;
        iv_t      iv;
        key_t     key;
        uut_out_t out_got;
        timer_t   tim_got;
        base = rec * `AT_WRITE_BYTES;
        iv   = exp_iv[blk];
        key  = exp_key[blk];
        check_addr(card.wr_addr[rec], `AT_START_BLOCK + blk, "written block address");
        if (card.wr_len[rec] != `AT_WRITE_BYTES)
            report_fault($sformatf("written block %0d has %0d bytes", rec, card.wr_len[rec]));
        for (i = 0; i < `AT_WRITE_BYTES; i++)
            check_byte(card.wr_data[base + i], expected_byte(blk, i, t),
                       $sformatf("block %0d byte %0d", rec, i));
        for (i = 0; i < `AT_OUT_BYTES; i++)
            out_got[8*i +: 8] = card.wr_data[base + `AT_OFS_OUT + i];
        for (i = 0; i < `AT_TIMER_BYTES; i++)
            tim_got[8*i +: 8] = card.wr_data[base + `AT_OFS_TIMER + i];
        check_out(out_got, iv[63:0] ^ key[63:0], "UUT output field");
        check_timer(tim_got, t, "timer field");
    endtask

    task automatic close_test(input string name);
        tests_run++;
        if (test_errors == 0)
            $display("test %s passed", name);
        else
        begin
            $display("test %s failed with %0d errors", name, test_errors);
            tests_failed++;
        end
        errors = errors + test_errors;
        test_errors = 0;
    endtask

    task automatic load_and_run();
        int   i;
        iv_t  iv;
        key_t key;
        fill_card();
        prepare_block(0, 1'b1);
        end_en    = 1'b1;
        end_after = 37;
        apply_reset();
        if ({spi_rst, spi_r_block, spi_r_byte, spi_w_block, spi_w_byte} !== 5'b0)
            report_fault("a host command is active right after reset");
        if (rst_uut !== 1'b1 || halted !== 1'b0)
            report_fault("UUT reset or halted flag is wrong right after reset");
        while (rst_uut)
            @(negedge clk);
        iv  = exp_iv[0];
        key = exp_key[0];
        for (i = 0; i < `AT_IV_BYTES; i++)
            check_byte(iv_uut[8*i +: 8], iv[8*i +: 8], $sformatf("iv_uut_o byte %0d", i));
        for (i = 0; i < `AT_KEY_BYTES; i++)
            check_byte(key_uut[8*i +: 8], key[8*i +: 8], $sformatf("key_uut_o byte %0d", i));
        wait_writes(1);
        verify_record(0, 0, timer_t'(37));
        close_test("load_and_run");
    endtask

    task automatic timeout_run();
        fill_card();
        prepare_block(0, 1'b1);
        end_en = 1'b0;
        apply_reset();
        wait_writes(1);
        verify_record(0, 0, timer_t'(`AT_TIMEOUT));
        close_test("timeout_run");
    endtask

    task automatic bad_signature();
        int drops;
        drops = 0;
        fill_card();
        prepare_block(0, 1'b0);
        end_en    = 1'b1;
        end_after = 37;
        apply_reset();
        while (!halted)
            @(negedge clk);
        repeat (200)
        begin
            @(negedge clk);
            if (halted !== 1'b1 || spi_w_block !== 1'b0 || rst_uut !== 1'b1)
                drops++;
        end
        if (drops != 0)
            report_fault("controller left the halted state after a bad signature");
        @(posedge clk);
        if (card.wr_count != 0)
            report_fault("a block with a bad signature was written back");
        close_test("bad_signature");
    endtask

    task automatic two_blocks();
        fill_card();
        prepare_block(0, 1'b1);
        prepare_block(1, 1'b1);
        end_en    = 1'b1;
        end_after = 20;
        apply_reset();
        wait_writes(2);
        verify_record(0, 0, timer_t'(20));
        verify_record(1, 1, timer_t'(20));
        close_test("two_blocks");
    endtask

    initial
    begin
        rst          = 1'b1;
        end_uut      = 1'b0;
        block_o_uut  = '0;
        end_en       = 1'b0;
        end_after    = 0;
        seed         = 12943;
        test_errors  = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        load_and_run();
        timeout_run();
        bad_signature();
        two_blocks();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule : tb_autotest

//--- verif/sd_card_model.sv
// behavioral SPI SD host; holds NBLK blocks from AT_START_BLOCK, records up to NBLK written blocks
`timescale 1ns/1ps
`include "autotest_cfg.svh"

module sd_card_model import autotest_pkg::*;
#(
    parameter int BUSY_LEN = 2,
    parameter int NBLK     = 4
)
(
    input  logic        clk,
    input  logic        rst,
    input  logic        spi_rst_i,
    input  logic        spi_r_block_i,
    input  logic        spi_r_byte_i,
    input  logic        spi_w_block_i,
    input  logic        spi_w_byte_i,
    input  block_addr_t spi_block_addr_i,
    input  byte_t       spi_data_in_i,
    output logic        spi_busy_o,
    output byte_t       spi_data_out_o
);

    byte_t       store   [0:NBLK*`AT_BLOCK_BYTES-1];
    byte_t       wr_data [0:NBLK*`AT_WRITE_BYTES-1];
    block_addr_t wr_addr [0:NBLK-1];
    int          wr_len  [0:NBLK-1];
    int          wr_count = 0;

    logic        rst_q = 1'b1;
    int          busy_cnt = 0;
    logic        rd_pending = 1'b0;
    logic        rst_open = 1'b0;
    logic        rd_open = 1'b0;
    logic        wr_open = 1'b0;
    block_addr_t base_addr = '0;
    int          ptr = 0;

    initial
    begin
        spi_busy_o     = 1'b0;
        spi_data_out_o = 8'hFF;
    end

    function automatic byte_t read_byte(input block_addr_t addr, input int pos);
        block_addr_t blk;
        blk = addr - `AT_START_BLOCK;
        if (addr >= `AT_START_BLOCK && blk < NBLK && pos < `AT_BLOCK_BYTES)
            return store[int'(blk) * `AT_BLOCK_BYTES + pos];
        return 8'hFF;
    endfunction

    task automatic raise_busy();
        spi_busy_o <= 1'b1;
        busy_cnt = BUSY_LEN;
    endtask

    always @(posedge clk)
        rst_q <= rst;

    always @(negedge clk)
    begin
        if (rst_q)
        begin
            spi_busy_o     <= 1'b0;
            spi_data_out_o <= 8'hFF;
            busy_cnt   = 0;
            rd_pending = 1'b0;
            rst_open   = 1'b0;
            rd_open    = 1'b0;
            wr_open    = 1'b0;
            ptr        = 0;
            wr_count   = 0;
        end
        else if (busy_cnt > 0)
        begin
            busy_cnt = busy_cnt - 1;
            if (busy_cnt == 0)
            begin
                spi_busy_o <= 1'b0;
                // read data is valid once busy falls
                if (rd_pending)
                begin
                    spi_data_out_o <= read_byte(base_addr, ptr);
                    ptr        = ptr + 1;
                    rd_pending = 1'b0;
                end
            end
        end
        else
        begin
            // block commands close when the controller drops them
            if (rst_open && !spi_rst_i)
                rst_open = 1'b0;
            if (rd_open && !spi_r_block_i)
                rd_open = 1'b0;
            if (wr_open && !spi_w_block_i)
            begin
                wr_open = 1'b0;
                if (wr_count < NBLK)
                begin
                    wr_addr[wr_count] = base_addr;
                    wr_len[wr_count]  = ptr;
                end
                wr_count = wr_count + 1;
            end

            if (spi_rst_i && !rst_open)
            begin
                rst_open = 1'b1;
                raise_busy();
            end
            else if (spi_r_block_i && !rd_open)
            begin
                rd_open   = 1'b1;
                base_addr = spi_block_addr_i;
                ptr       = 0;
                raise_busy();
            end
            else if (rd_open && spi_r_byte_i)
            begin
                rd_pending = 1'b1;
                raise_busy();
            end
            else if (spi_w_block_i && !wr_open)
            begin
                wr_open   = 1'b1;
                base_addr = spi_block_addr_i;
                ptr       = 0;
                raise_busy();
            end
            else if (wr_open && spi_w_byte_i)
            begin
                // host takes the data byte as it raises busy
                if (wr_count < NBLK && ptr < `AT_WRITE_BYTES)
                    wr_data[wr_count * `AT_WRITE_BYTES + ptr] = spi_data_in_i;
                ptr = ptr + 1;
                raise_busy();
            end
        end
    end

endmodule : sd_card_model

//--- design/autotest_top.sv
// SPI host error and CRC flags are not connected; one block per test, halts on a bad signature
`timescale 1ns/1ps

module autotest_top import autotest_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        spi_busy_i,
    input  byte_t       spi_data_out_i,
    output logic        spi_rst_o,
    output logic        spi_r_block_o,
    output logic        spi_r_byte_o,
    output logic        spi_w_block_o,
    output logic        spi_w_byte_o,
    output block_addr_t spi_block_addr_o,
    output byte_t       spi_data_in_o,
    output logic        rst_uut_o,
    output iv_t         iv_uut_o,
    output key_t        key_uut_o,
    input  uut_out_t    block_o_uut_i,
    input  logic        end_uut_i,
    output logic        halted_o
);

    logic      rx_valid;
    logic      load_clear;
    logic      sig_ok;
    logic      run;
    logic      run_done;
    logic      tx_load;
    byte_idx_t byte_idx;
    byte_t     iter;
    sig_t      sig;
    uut_out_t  result;
    timer_t    timer;

    sd_sequencer u_sequencer (
        .clk              (clk),
        .rst              (rst),
        .spi_busy_i       (spi_busy_i),
        .spi_rst_o        (spi_rst_o),
        .spi_r_block_o    (spi_r_block_o),
        .spi_r_byte_o     (spi_r_byte_o),
        .spi_w_block_o    (spi_w_block_o),
        .spi_w_byte_o     (spi_w_byte_o),
        .spi_block_addr_o (spi_block_addr_o),
        .rx_valid_o       (rx_valid),
        .load_clear_o     (load_clear),
        .byte_idx_o       (byte_idx),
        .sig_ok_i         (sig_ok),
        .run_o            (run),
        .run_done_i       (run_done),
        .tx_load_o        (tx_load),
        .halted_o         (halted_o)
    );

    vector_loader u_loader (
        .clk        (clk),
        .rst        (rst),
        .clear_i    (load_clear),
        .rx_valid_i (rx_valid),
        .byte_idx_i (byte_idx),
        .byte_i     (spi_data_out_i),
        .sig_ok_o   (sig_ok),
        .iter_o     (iter),
        .iv_o       (iv_uut_o),
        .key_o      (key_uut_o),
        .sig_o      (sig)
    );

    uut_runner u_runner (
        .clk           (clk),
        .rst           (rst),
        .run_i         (run),
        .end_uut_i     (end_uut_i),
        .block_o_uut_i (block_o_uut_i),
        .rst_uut_o     (rst_uut_o),
        .run_done_o    (run_done),
        .result_o      (result),
        .timer_o       (timer)
    );

    result_serializer u_serializer (
        .clk        (clk),
        .rst        (rst),
        .tx_load_i  (tx_load),
        .byte_idx_i (byte_idx),
        .sig_i      (sig),
        .iter_i     (iter),
        .iv_i       (iv_uut_o),
        .key_i      (key_uut_o),
        .result_i   (result),
        .timer_i    (timer),
        .spi_data_o (spi_data_in_o)
    );

endmodule : autotest_top

//--- design/result_serializer.sv
// spi_data_o holds its byte until the next tx_load_i; unused block bytes go out as FF
`timescale 1ns/1ps
`include "autotest_cfg.svh"

module result_serializer import autotest_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      tx_load_i,
    input  byte_idx_t byte_idx_i,
    input  sig_t      sig_i,
    input  byte_t     iter_i,
    input  iv_t       iv_i,
    input  key_t      key_i,
    input  uut_out_t  result_i,
    input  timer_t    timer_i,
    output byte_t     spi_data_o
);

    byte_t tx_byte;
    byte_t data_q;
    int    idx;

    assign idx = int'(byte_idx_i);

    always_comb
    begin
        tx_byte = 8'hFF;
        if (idx < `AT_OFS_ITER)
            // signature goes out big-endian
            tx_byte = sig_i[8*(3 - (idx - `AT_OFS_SIG)) +: 8];
        else if (idx == `AT_OFS_ITER)
            tx_byte = iter_i;
        else if (idx >= `AT_OFS_IV && idx < `AT_OFS_IV + `AT_IV_BYTES)
            tx_byte = iv_i[8*(idx - `AT_OFS_IV) +: 8];
        else if (idx >= `AT_OFS_KEY && idx < `AT_OFS_KEY + `AT_KEY_BYTES)
            tx_byte = key_i[8*(idx - `AT_OFS_KEY) +: 8];
        else if (idx >= `AT_OFS_OUT && idx < `AT_OFS_OUT + `AT_OUT_BYTES)
            tx_byte = result_i[8*(idx - `AT_OFS_OUT) +: 8];
        else if (idx >= `AT_OFS_TIMER && idx < `AT_OFS_TIMER + `AT_TIMER_BYTES)
            tx_byte = timer_i[8*(idx - `AT_OFS_TIMER) +: 8];
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            data_q <= 8'hFF;
        else if (tx_load_i)
            data_q <= tx_byte;
    end

    assign spi_data_o = data_q;

endmodule : result_serializer

//--- design/sd_sequencer.sv
// waits on spi_busy without limit; a bad signature halts until rst, spi error flags are not watched
`timescale 1ns/1ps
`include "autotest_cfg.svh"

module sd_sequencer import autotest_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        spi_busy_i,
    output logic        spi_rst_o,
    output logic        spi_r_block_o,
    output logic        spi_r_byte_o,
    output logic        spi_w_block_o,
    output logic        spi_w_byte_o,
    output block_addr_t spi_block_addr_o,
    output logic        rx_valid_o,
    output logic        load_clear_o,
    output byte_idx_t   byte_idx_o,
    input  logic        sig_ok_i,
    output logic        run_o,
    input  logic        run_done_i,
    output logic        tx_load_o,
    output logic        halted_o
);

    typedef enum logic [4:0] {
        S_IDLE,
        S_HOST_RST,
        S_HOST_RST_WAIT,
        S_RD_BLOCK,
        S_RD_BLOCK_WAIT,
        S_RD_BYTE,
        S_RD_BYTE_WAIT,
        S_RD_DATA,
        S_CHECK,
        S_RUN_WAIT,
        S_WR_BLOCK,
        S_WR_BLOCK_WAIT,
        S_WR_LOAD,
        S_WR_BYTE,
        S_WR_BYTE_WAIT,
        S_NEXT,
        S_HALT
    } state_t;

    state_t      state_q;
    state_t      state_d;
    byte_idx_t   byte_cnt_q;
    block_addr_t addr_q;
    logic        last_rd;
    logic        last_wr;

    assign last_rd = (byte_cnt_q == byte_idx_t'(`AT_BLOCK_BYTES - 1));
    assign last_wr = (byte_cnt_q == byte_idx_t'(`AT_WRITE_BYTES - 1));

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            S_IDLE:          state_d = S_HOST_RST;
            S_HOST_RST:      if (spi_busy_i) state_d = S_HOST_RST_WAIT;
            S_HOST_RST_WAIT: if (!spi_busy_i) state_d = S_RD_BLOCK;
            S_RD_BLOCK:      if (spi_busy_i) state_d = S_RD_BLOCK_WAIT;
            S_RD_BLOCK_WAIT: if (!spi_busy_i) state_d = S_RD_BYTE;
            S_RD_BYTE:       if (spi_busy_i) state_d = S_RD_BYTE_WAIT;
            S_RD_BYTE_WAIT:  if (!spi_busy_i) state_d = S_RD_DATA;
            S_RD_DATA:       state_d = last_rd ? S_CHECK : S_RD_BYTE;
            S_CHECK:         state_d = sig_ok_i ? S_RUN_WAIT : S_HALT;
            S_RUN_WAIT:      if (run_done_i) state_d = S_WR_BLOCK;
            S_WR_BLOCK:      if (spi_busy_i) state_d = S_WR_BLOCK_WAIT;
            S_WR_BLOCK_WAIT: if (!spi_busy_i) state_d = S_WR_LOAD;
            S_WR_LOAD:       state_d = S_WR_BYTE;
            S_WR_BYTE:       if (spi_busy_i) state_d = S_WR_BYTE_WAIT;
            S_WR_BYTE_WAIT:
            begin
                if (!spi_busy_i)
                    state_d = last_wr ? S_NEXT : S_WR_LOAD;
            end
            S_NEXT:          state_d = S_IDLE;
            S_HALT:          state_d = S_HALT;
            default:         state_d = S_HALT;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q    <= S_IDLE;
            byte_cnt_q <= '0;
            addr_q     <= `AT_START_BLOCK;
        end
        else
        begin
            state_q <= state_d;
            // byte counter restarts for the read and again for the write
            if (state_q == S_IDLE || state_q == S_CHECK)
                byte_cnt_q <= '0;
            else if (state_q == S_RD_DATA)
                byte_cnt_q <= byte_cnt_q + 1'b1;
            else if (state_q == S_WR_BYTE_WAIT && !spi_busy_i)
                byte_cnt_q <= byte_cnt_q + 1'b1;
            if (state_q == S_NEXT)
                addr_q <= addr_q + 1'b1;
        end
    end

    assign spi_rst_o     = (state_q == S_HOST_RST) || (state_q == S_HOST_RST_WAIT);
    // block commands stay up for the whole transfer
    assign spi_r_block_o = (state_q >= S_RD_BLOCK) && (state_q <= S_RD_DATA);
    assign spi_r_byte_o  = (state_q == S_RD_BYTE);
    assign spi_w_block_o = (state_q >= S_WR_BLOCK) && (state_q <= S_WR_BYTE_WAIT);
    assign spi_w_byte_o  = (state_q == S_WR_BYTE);

    assign spi_block_addr_o = addr_q;
    assign byte_idx_o       = byte_cnt_q;
    assign load_clear_o     = (state_q == S_IDLE);
    assign rx_valid_o       = (state_q == S_RD_DATA);
    assign run_o            = (state_q == S_CHECK) && sig_ok_i;
    assign tx_load_o        = (state_q == S_WR_LOAD);
    assign halted_o         = (state_q == S_HALT);

endmodule : sd_sequencer

//--- design/uut_runner.sv
// one run per run_i pulse; run_i while a run is active restarts the timer
`timescale 1ns/1ps
`include "autotest_cfg.svh"

module uut_runner import autotest_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     run_i,
    input  logic     end_uut_i,
    input  uut_out_t block_o_uut_i,
    output logic     rst_uut_o,
    output logic     run_done_o,
    output uut_out_t result_o,
    output timer_t   timer_o
);

    logic     rst_uut_q;
    logic     run_done_q;
    logic     timed_out;
    logic     finish;
    timer_t   timer_q;
    uut_out_t result_q;

    assign timed_out = (timer_q == timer_t'(`AT_TIMEOUT));
    // UUT is running whenever its reset is released
    assign finish    = !rst_uut_q && (end_uut_i || timed_out);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rst_uut_q  <= 1'b1;
            run_done_q <= 1'b0;
            timer_q    <= '0;
        end
        else
        begin
            run_done_q <= 1'b0;
            if (run_i)
            begin
                rst_uut_q <= 1'b0;
                timer_q   <= '0;
            end
            else if (finish)
            begin
                rst_uut_q  <= 1'b1;
                run_done_q <= 1'b1;
            end
            else if (!rst_uut_q)
                timer_q <= timer_q + 1'b1;
        end
    end

    // output snapshot taken in the cycle that ends the run
    always_ff @(posedge clk)
    begin
        if (finish)
            result_q <= block_o_uut_i;
    end

    assign rst_uut_o  = rst_uut_q;
    assign run_done_o = run_done_q;
    assign result_o   = result_q;
    assign timer_o    = timer_q;

endmodule : uut_runner

//--- design/vector_loader.sv
// header fields of the current block; sig_ok_o is only meaningful after byte 3 was received
`timescale 1ns/1ps
`include "autotest_cfg.svh"

module vector_loader import autotest_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      clear_i,
    input  logic      rx_valid_i,
    input  byte_idx_t byte_idx_i,
    input  byte_t     byte_i,
    output logic      sig_ok_o,
    output byte_t     iter_o,
    output iv_t       iv_o,
    output key_t      key_o,
    output sig_t      sig_o
);

    byte_t iter_q;

    // signature arrives most significant byte first
    byte_field_reg #(.field_t(sig_t), .OFFSET(`AT_OFS_SIG), .MSB_FIRST(1'b1)) u_sig (
        .clk        (clk),
        .rst        (rst),
        .clear_i    (clear_i),
        .rx_valid_i (rx_valid_i),
        .byte_idx_i (byte_idx_i),
        .byte_i     (byte_i),
        .field_o    (sig_o)
    );

    byte_field_reg #(.field_t(iv_t), .OFFSET(`AT_OFS_IV), .MSB_FIRST(1'b0)) u_iv (
        .clk        (clk),
        .rst        (rst),
        .clear_i    (clear_i),
        .rx_valid_i (rx_valid_i),
        .byte_idx_i (byte_idx_i),
        .byte_i     (byte_i),
        .field_o    (iv_o)
    );

    byte_field_reg #(.field_t(key_t), .OFFSET(`AT_OFS_KEY), .MSB_FIRST(1'b0)) u_key (
        .clk        (clk),
        .rst        (rst),
        .clear_i    (clear_i),
        .rx_valid_i (rx_valid_i),
        .byte_idx_i (byte_idx_i),
        .byte_i     (byte_i),
        .field_o    (key_o)
    );

    // iteration count is only echoed in the result record
    always_ff @(posedge clk)
    begin
        if (rst || clear_i)
            iter_q <= '0;
        else if (rx_valid_i && byte_idx_i == byte_idx_t'(`AT_OFS_ITER))
            iter_q <= byte_i;
    end

    assign iter_o   = iter_q;
    assign sig_ok_o = (sig_o == `AT_SIG_VALUE);

endmodule : vector_loader

//--- design/byte_field_reg.sv
// field_t must be a packed vector of whole bytes; bytes outside the field are ignored
`timescale 1ns/1ps

module byte_field_reg import autotest_pkg::*;
#(
    parameter type field_t   = sig_t,
    parameter int  OFFSET    = 0,
    parameter bit  MSB_FIRST = 1'b0
)
(
    input  logic      clk,
    input  logic      rst,
    input  logic      clear_i,
    input  logic      rx_valid_i,
    input  byte_idx_t byte_idx_i,
    input  byte_t     byte_i,
    output field_t    field_o
);

    localparam int NB = $bits(field_t) / 8;

    field_t    field_q;
    byte_idx_t rel;
    logic      in_field;
    int        lane;

    assign rel      = byte_idx_i - byte_idx_t'(OFFSET);
    assign in_field = (byte_idx_i >= byte_idx_t'(OFFSET)) && (rel < byte_idx_t'(NB));
    // big-endian fields land their first byte in the top lane
    assign lane     = MSB_FIRST ? (NB - 1 - int'(rel)) : int'(rel);

    always_ff @(posedge clk)
    begin
        if (rst || clear_i)
            field_q <= '0;
        else if (rx_valid_i && in_field)
            field_q[8*lane +: 8] <= byte_i;
    end

    assign field_o = field_q;

endmodule : byte_field_reg

//--- design/autotest_pkg.sv
// shared types; the wide field types take their byte counts from autotest_cfg.svh
`include "autotest_cfg.svh"

package autotest_pkg;

    // one card byte
    typedef logic [7:0] byte_t;

    // position inside a block transfer, covers the 516-byte write
    typedef logic [9:0] byte_idx_t;

    typedef logic [31:0] block_addr_t;

    typedef logic [31:0] sig_t;

    // UUT parameters
    typedef logic [`AT_IV_BYTES*8-1:0]  iv_t;
    typedef logic [`AT_KEY_BYTES*8-1:0] key_t;

    // UUT result and run length
    typedef logic [`AT_OUT_BYTES*8-1:0]   uut_out_t;
    typedef logic [`AT_TIMER_BYTES*8-1:0] timer_t;

endpackage : autotest_pkg

//--- design/autotest_cfg.svh
// field widths, header layout and limits; widths must stay whole bytes and AT_WRITE_BYTES < 1024
`ifndef AUTOTEST_CFG_SVH
`define AUTOTEST_CFG_SVH

// field lengths in bytes
`define AT_IV_BYTES     10
`define AT_KEY_BYTES    10
`define AT_OUT_BYTES    8
`define AT_TIMER_BYTES  8

`define AT_SIG_VALUE    32'hAABB_CCDD
`define AT_START_BLOCK  32'h0010_0000

// card block plus the trailing pad bytes sent on a write
`define AT_BLOCK_BYTES  512
`define AT_WRITE_BYTES  516

// run cycles before the UUT is forced back into reset
`define AT_TIMEOUT      4096

// header byte offsets
`define AT_OFS_SIG      0
`define AT_OFS_ITER     4
`define AT_OFS_IV       5
`define AT_OFS_KEY      15
`define AT_OFS_OUT      25
`define AT_OFS_TIMER    33

`endif
